//--- rv_pkg.sv
/* RV32I integer core shared definitions */

`default_nettype none

package rv_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------

    localparam int xlen     = 32;
    // instruction memory address width
    localparam int pc_width = 32;

    // ----------------------------------------------------------------------
    // encodings
    // ----------------------------------------------------------------------

    // major opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    // funct3, shared by the register and immediate forms
    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_slt = 3'b010;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or  = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;

    // funct7, register form only
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_sub  = 7'b0100000;

    // ----------------------------------------------------------------------
    // types
    // ----------------------------------------------------------------------

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_xor,
        alu_or,
        alu_and
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // rs2/funct7 and imm12 occupy the same upper bits
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

endpackage

`default_nettype wire

//--- stage_if.sv
/* decode to execute bundle */

`timescale 1ns/1ps
`default_nettype none

interface id_ex_if import rv_pkg::*; ();

    // one-cycle strobe per instruction, no back-pressure
    logic              valid;
    alu_op_t           alu_op;
    logic [xlen-1:0]   op_a;
    logic [xlen-1:0]   op_b;
    logic [4:0]        rd;

    modport producer (
        output valid,
        output alu_op,
        output op_a,
        output op_b,
        output rd
    );

    modport consumer (
        input valid,
        input alu_op,
        input op_a,
        input op_b,
        input rd
    );

endinterface

`default_nettype wire

//--- fetch_stage.sv
/* instruction fetch stage */

`timescale 1ns/1ps
`default_nettype none

module fetch_stage import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    // instruction memory port
    output logic                instr_req,
    output logic [pc_width-1:0] instr_addr,
    input  logic                instr_gnt,
    input  instr_t              instr_data,

    // to decode
    output logic                fd_valid,
    output logic [pc_width-1:0] fd_pc,
    output instr_t              fd_instr
);

    logic [pc_width-1:0] pc;
    logic                granted;

    assign granted    = instr_req & instr_gnt;
    // address held stable until the grant edge
    assign instr_addr = pc;

    // ----------------------------------------------------------------------
    // request and program counter
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_req <= 1'b0;
            pc        <= '0;
            fd_valid  <= 1'b0;
        end else begin
            // request continuously once out of reset
            instr_req <= 1'b1;
            fd_valid  <= granted;
            if (granted) begin
                pc <= pc + pc_width'(4);
            end
        end
    end

    // fetched word and its address
    always_ff @(posedge clk) begin
        if (granted) begin
            fd_pc    <= pc;
            fd_instr <= instr_data;
        end
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
/* instruction decode and register file */

`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    // from fetch
    input  logic                fd_valid,
    input  logic [pc_width-1:0] fd_pc,
    input  instr_t              fd_instr,

    // to execute
    id_ex_if.producer           id_ex,

    // forwarding from the ALU output
    input  logic                ex_fwd_valid,
    input  logic [4:0]          ex_fwd_rd,
    input  logic [xlen-1:0]     ex_fwd_data,

    // writeback register
    input  logic                wb_valid,
    input  logic [4:0]          wb_rd,
    input  logic [xlen-1:0]     wb_data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    logic            f3_ok;
    alu_op_t         f3_op;
    logic            dec_ok;
    alu_op_t         dec_op;
    logic            use_imm;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    // ----------------------------------------------------------------------
    // decode
    // ----------------------------------------------------------------------

    // funct3 names the same operation in both formats
    always_comb begin
        f3_ok = 1'b1;
        f3_op = alu_add;
        case (fd_instr.r.funct3)
            funct3_add: f3_op = alu_add;
            funct3_slt: f3_op = alu_slt;
            funct3_xor: f3_op = alu_xor;
            funct3_or:  f3_op = alu_or;
            funct3_and: f3_op = alu_and;
            default:    f3_ok = 1'b0;
        endcase
    end

    always_comb begin
        dec_ok  = 1'b0;
        dec_op  = f3_op;
        use_imm = 1'b0;
        if (fd_instr.r.opcode == opcode_op) begin
            if (fd_instr.r.funct7 == funct7_base) begin
                dec_ok = f3_ok;
            end else if (fd_instr.r.funct7 == funct7_sub &&
                         fd_instr.r.funct3 == funct3_add) begin
                dec_ok = 1'b1;
                dec_op = alu_sub;
            end
        end else if (fd_instr.i.opcode == opcode_op_imm) begin
            dec_ok  = f3_ok;
            use_imm = 1'b1;
        end
    end

    assign imm_ext = {{(xlen-12){fd_instr.i.imm12[11]}}, fd_instr.i.imm12};

    // ----------------------------------------------------------------------
    // operand read with forwarding
    // ----------------------------------------------------------------------

    // newest value wins: execute, then writeback, then the file
    function automatic logic [xlen-1:0] read_operand(input logic [4:0] rs);
        logic [xlen-1:0] value;
        if (rs == 5'd0) begin
            value = '0;
        end else if (ex_fwd_valid && ex_fwd_rd == rs) begin
            value = ex_fwd_data;
        end else if (wb_valid && wb_rd == rs) begin
            value = wb_data;
        end else begin
            value = regs[rs];
        end
        return value;
    endfunction

    always_comb begin
        rs1_val = read_operand(fd_instr.r.rs1);
        rs2_val = read_operand(fd_instr.r.rs2);
    end

    // register file write
    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // ----------------------------------------------------------------------
    // decode to execute register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= fd_valid & dec_ok;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.alu_op <= dec_op;
        id_ex.op_a   <= rs1_val;
        id_ex.op_b   <= use_imm ? imm_ext : rs2_val;
        id_ex.rd     <= fd_instr.r.rd;
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
/* execute stage and writeback register */

`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    // from decode
    id_ex_if.consumer       id_ex,

    // combinational result for forwarding
    output logic            ex_fwd_valid,
    output logic [4:0]      ex_fwd_rd,
    output logic [xlen-1:0] ex_fwd_data,

    // writeback register, also the retire port
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data
);

    logic [xlen-1:0] alu_result;
    logic            less_than;

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------

    assign less_than = $signed(id_ex.op_a) < $signed(id_ex.op_b);

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_result = id_ex.op_a + id_ex.op_b;
            alu_sub: alu_result = id_ex.op_a - id_ex.op_b;
            alu_slt: alu_result = {{(xlen-1){1'b0}}, less_than};
            alu_xor: alu_result = id_ex.op_a ^ id_ex.op_b;
            alu_or:  alu_result = id_ex.op_a | id_ex.op_b;
            alu_and: alu_result = id_ex.op_a & id_ex.op_b;
            default: alu_result = '0;
        endcase
    end

    assign ex_fwd_valid = id_ex.valid;
    assign ex_fwd_rd    = id_ex.rd;
    assign ex_fwd_data  = alu_result;

    // ----------------------------------------------------------------------
    // writeback register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= id_ex.valid;
        end
    end

    // writes to x0 retire as zero
    always_ff @(posedge clk) begin
        wb_rd   <= id_ex.rd;
        wb_data <= (id_ex.rd == 5'd0) ? '0 : alu_result;
    end

endmodule

`default_nettype wire

//--- rv_core.sv
/* RV32I four-stage ALU core */

`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    // instruction fetch port
    output logic                instr_req,
    output logic [pc_width-1:0] instr_addr,
    input  logic                instr_gnt,
    input  instr_t              instr_data,

    // retire port
    output logic                retire_valid,
    output logic [4:0]          retire_rd,
    output logic [xlen-1:0]     retire_data
);

    // fetch to decode
    logic                fd_valid;
    logic [pc_width-1:0] fd_pc;
    instr_t              fd_instr;

    // execute forwarding path
    logic                ex_fwd_valid;
    logic [4:0]          ex_fwd_rd;
    logic [xlen-1:0]     ex_fwd_data;

    id_ex_if id_ex ();

    fetch_stage u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_req  (instr_req),
        .instr_addr (instr_addr),
        .instr_gnt  (instr_gnt),
        .instr_data (instr_data),
        .fd_valid   (fd_valid),
        .fd_pc      (fd_pc),
        .fd_instr   (fd_instr)
    );

    // writeback feeds both the retire port and the register file
    decode_stage u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .fd_valid     (fd_valid),
        .fd_pc        (fd_pc),
        .fd_instr     (fd_instr),
        .id_ex        (id_ex.producer),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .wb_valid     (retire_valid),
        .wb_rd        (retire_rd),
        .wb_data      (retire_data)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_ex        (id_ex.consumer),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .wb_valid     (retire_valid),
        .wb_rd        (retire_rd),
        .wb_data      (retire_data)
    );

endmodule

`default_nettype wire

//--- rv_core_assertions.sv
/* RV32I core retire checker */

`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions import rv_pkg::*; (
    input logic                clk,
    input logic                rst_n,
    input logic                instr_req,
    input logic [pc_width-1:0] instr_addr,
    input logic                instr_gnt,
    input instr_t              instr_data,
    input logic                retire_valid,
    input logic [4:0]          retire_rd,
    input logic [xlen-1:0]     retire_data
);

    // architectural register model
    logic [xlen-1:0] shadow [0:31];
    logic [4:0]      exp_rd   [0:7];
    logic [xlen-1:0] exp_data [0:7];
    logic [2:0]      wr_ptr;
    logic [2:0]      rd_ptr;
    logic            granted;
    logic [xlen:0]   model_out;
    logic            word_ok;
    logic            failed;

    initial begin
        failed = 1'b0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
    end

    // {supported, result} for one word against the shadow registers
    function automatic logic [xlen:0] model(input instr_t w);
        logic            ok;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] r;
        ok = 1'b0;
        r  = '0;
        a  = shadow[w.r.rs1];
        b  = shadow[w.r.rs2];
        if (w.i.opcode == opcode_op_imm) begin
            b = {{(xlen-12){w.i.imm12[11]}}, w.i.imm12};
        end
        if (w.r.opcode == opcode_op && w.r.funct7 == funct7_sub) begin
            ok = (w.r.funct3 == funct3_add);
            r  = a - b;
        end else if ((w.r.opcode == opcode_op && w.r.funct7 == funct7_base) ||
                     w.i.opcode == opcode_op_imm) begin
            ok = 1'b1;
            case (w.r.funct3)
                funct3_add: r = a + b;
                funct3_slt: r = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
                funct3_xor: r = a ^ b;
                funct3_or:  r = a | b;
                funct3_and: r = a & b;
                default:    ok = 1'b0;
            endcase
        end
        if (w.r.rd == 5'd0) begin
            r = '0;
        end
        return {ok, r};
    endfunction

    assign granted = instr_req & instr_gnt;

    always_comb begin
        model_out = model(instr_data);
    end

    assign word_ok = model_out[xlen];

    // ----------------------------------------------------------------------
    // in-order expected retire queue
    // ----------------------------------------------------------------------

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (granted && word_ok) begin
                exp_rd[wr_ptr]   <= instr_data.r.rd;
                exp_data[wr_ptr] <= model_out[xlen-1:0];
                wr_ptr           <= wr_ptr + 3'd1;
                if (instr_data.r.rd != 5'd0) begin
                    shadow[instr_data.r.rd] <= model_out[xlen-1:0];
                end
            end
            if (retire_valid) begin
                rd_ptr <= rd_ptr + 3'd1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // properties
    // ----------------------------------------------------------------------

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !instr_req && !retire_valid)
        else begin failed = 1'b1; $error("request or retire active during reset"); end

    a_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !instr_req && !retire_valid && instr_addr == '0)
        else begin failed = 1'b1; $error("Fail instr_addr %h after reset", instr_addr); end

    a_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_req) |-> instr_addr == '0)
        else begin failed = 1'b1; $error("Fail instr_addr %h on first request", instr_addr); end

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req && !instr_gnt |=> $stable(instr_addr))
        else begin failed = 1'b1; $error("Fail instr_addr %h moved without grant", instr_addr); end

    a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        granted |=> instr_addr == $past(instr_addr) + 32'd4)
        else begin failed = 1'b1; $error("Fail instr_addr %h after grant", instr_addr); end

    a_retire_time: assert property (@(posedge clk) disable iff (!rst_n)
        granted && word_ok |-> ##3 retire_valid)
        else begin failed = 1'b1; $error("supported instruction did not retire on time"); end

    a_no_retire: assert property (@(posedge clk) disable iff (!rst_n)
        granted && !word_ok |-> ##3 !retire_valid)
        else begin failed = 1'b1; $error("unsupported instruction retired"); end

    a_retire_rd: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> wr_ptr != rd_ptr && retire_rd == exp_rd[rd_ptr])
        else begin
            failed = 1'b1;
            $error("Fail retire_rd %h expected %h", retire_rd, exp_rd[rd_ptr]);
        end

    a_retire_data: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_data == exp_data[rd_ptr])
        else begin
            failed = 1'b1;
            $error("Fail retire_data %h expected %h", retire_data, exp_data[rd_ptr]);
        end

endmodule

bind rv_core rv_core_assertions chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_req    (instr_req),
    .instr_addr   (instr_addr),
    .instr_gnt    (instr_gnt),
    .instr_data   (instr_data),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
);

`default_nettype wire

//--- tb_rv_core.sv
/* RV32I core testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    logic                clk;
    logic                rst_n;
    logic                instr_req;
    logic [pc_width-1:0] instr_addr;
    logic                instr_gnt;
    instr_t              instr_data;
    logic                retire_valid;
    logic [4:0]          retire_rd;
    logic [xlen-1:0]     retire_data;

    instr_t      mem [0:1023];
    logic [31:0] lfsr;
    logic        stall_en;
    int          prog_len;
    int          expected;
    int          retire_count;

    rv_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_req    (instr_req),
        .instr_addr   (instr_addr),
        .instr_gnt    (instr_gnt),
        .instr_data   (instr_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #2 clk = ~clk;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        instr_t w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: opcode_op};
        return w;
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
        instr_t w;
        w.i = '{imm12: imm, rs1: rs1, funct3: f3, rd: rd, opcode: opcode_op_imm};
        return w;
    endfunction

    // unused words carry an illegal opcode and their own word index
    task automatic clear_program();
        for (int k = 0; k < 1024; k++) begin
            mem[k] = {k[24:0], 7'h7f};
        end
        prog_len = 0;
        expected = 0;
    endtask

    task automatic put_word(input instr_t w, input logic retires);
        mem[prog_len] = w;
        prog_len      = prog_len + 1;
        if (retires) begin
            expected = expected + 1;
        end
    endtask

    task automatic hold_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
    endtask

    task automatic release_reset();
        repeat (2) @(posedge clk);
        retire_count = 0;
        rst_n <= 1'b1;
    endtask

    task automatic wait_retired();
        int cycles;
        cycles = 0;
        while (retire_count < expected && cycles < 2000) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (retire_count < expected) begin
            $display("Simulation failed");
            $fatal(1, "timed out waiting for instructions to retire");
        end
        repeat (4) @(posedge clk);
    endtask

    // ----------------------------------------------------------------------
    // instruction memory, grant registered one cycle after the request
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        logic [pc_width-1:0] next_addr;
        logic                stall;
        next_addr = (instr_req && instr_gnt) ? instr_addr + 32'd4 : instr_addr;
        stall     = stall_en && (rand_bits(2) == 32'd0);
        if (!rst_n) begin
            instr_gnt <= 1'b0;
        end else begin
            instr_gnt  <= instr_req && !stall;
            instr_data <= mem[next_addr[11:2]];
        end
    end

    always @(posedge clk) begin
        if (rst_n && retire_valid) begin
            retire_count = retire_count + 1;
        end
        if (dut0.chk0.failed) begin
            $display("Simulation failed");
            $fatal(1, "checker assertion failed");
        end
    end

    // ----------------------------------------------------------------------
    // programs
    // ----------------------------------------------------------------------

    initial begin
        int          n;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr_gnt  = 1'b0;
        instr_data = '0;
        stall_en   = 1'b0;
        lfsr       = 32'd92414;
        retire_count = 0;

        // doubler, back-to-back adds through execute forwarding
        hold_reset();
        clear_program();
        put_word(enc_i(12'd1, 5'd0, funct3_add, 5'd1), 1'b1);
        n = 4 + int'(rand_bits(4));
        for (int k = 0; k < n; k++) begin
            put_word(enc_r(funct7_base, 5'd1, 5'd1, funct3_add, 5'd1), 1'b1);
        end
        release_reset();
        wait_retired();

        // fibonacci over x1, x2, x3
        hold_reset();
        clear_program();
        put_word(enc_i(12'd0, 5'd0, funct3_add, 5'd1), 1'b1);
        put_word(enc_i(12'd1, 5'd0, funct3_add, 5'd2), 1'b1);
        for (int k = 0; k < 6; k++) begin
            put_word(enc_r(funct7_base, 5'd2, 5'd1, funct3_add, 5'd3), 1'b1);
            put_word(enc_r(funct7_base, 5'd3, 5'd2, funct3_add, 5'd1), 1'b1);
            put_word(enc_r(funct7_base, 5'd1, 5'd3, funct3_add, 5'd2), 1'b1);
        end
        release_reset();
        wait_retired();

        // random mix with grant stalls
        hold_reset();
        clear_program();
        for (int k = 1; k < 32; k++) begin
            put_word(enc_i(12'(rand_bits(12)), 5'd0, funct3_add, 5'(k)), 1'b1);
        end
        for (int k = 0; k < 80; k++) begin
            // every kind once, then random kinds
            kind = (k < 16) ? 4'(k) : 4'(rand_bits(4));
            // every tenth word writes x0
            rd   = (k % 10 == 0) ? 5'd0 : 5'(rand_bits(5));
            rs1  = 5'(rand_bits(5));
            rs2  = 5'(rand_bits(5));
            imm  = 12'(rand_bits(12));
            case (kind)
                4'd0:  put_word(enc_r(funct7_base, rs2, rs1, funct3_add, rd), 1'b1);
                4'd1:  put_word(enc_r(funct7_sub, rs2, rs1, funct3_add, rd), 1'b1);
                4'd2:  put_word(enc_r(funct7_base, rs2, rs1, funct3_and, rd), 1'b1);
                4'd3:  put_word(enc_r(funct7_base, rs2, rs1, funct3_or, rd), 1'b1);
                4'd4:  put_word(enc_r(funct7_base, rs2, rs1, funct3_xor, rd), 1'b1);
                4'd5:  put_word(enc_r(funct7_base, rs2, rs1, funct3_slt, rd), 1'b1);
                4'd6:  put_word(enc_i(imm, rs1, funct3_add, rd), 1'b1);
                4'd7:  put_word(enc_i(imm, rs1, funct3_and, rd), 1'b1);
                4'd8:  put_word(enc_i(imm, rs1, funct3_or, rd), 1'b1);
                4'd9:  put_word(enc_i(imm, rs1, funct3_xor, rd), 1'b1);
                4'd10: put_word(enc_i(imm, rs1, funct3_slt, rd), 1'b1);
                // shift immediate and multiply forms are not supported
                4'd11, 4'd12: put_word(enc_i(imm, rs1, 3'b001, rd), 1'b0);
                default: put_word(enc_r(7'b0000001, rs2, rs1, funct3_add, rd), 1'b0);
            endcase
        end
        stall_en = 1'b1;
        release_reset();
        wait_retired();

        if (dut0.chk0.failed) begin
            $display("Simulation failed");
            $fatal(1, "checker assertion failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // overall limit on simulated time
    initial begin
        #100000;
        $display("Simulation failed");
        $fatal(1, "simulation ran past its time limit");
    end

endmodule

`default_nettype wire

//--- files.f
rv_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert --timing
LINT_FLAGS ?= --lint-only --assert --timing
TOP        ?= tb_rv_core
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
SIM        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
